//--- bench/calc_tb.sv
// Calculator testbench with vector reader, keypad driver, compare tasks and report
`default_nettype none
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_tb;
    import calc_pkg::*;

    localparam int KEY_TIMEOUT  = 100;
    localparam int DONE_TIMEOUT = 100;
    localparam int IGNORE_HOLD  = 30;

    logic                        clk;
    logic                        nRST;
    logic [`CALC_DIGIT_W-1:0]    keypad_digit;
    logic                        digit_valid;
    logic [$bits(op_code_t)-1:0] operator_key;
    logic                        equal_key;
    logic                        key_read;
    logic                        complete;
    logic [`CALC_WORD_W-1:0]     display_output;

    int errors;
    int tests_run;
    int tests_failed;
    int ack_total;
    int done_total;
    bit timed_out;

    calc_top dut0 (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_digit   (keypad_digit),
        .digit_valid    (digit_valid),
        .operator_key   (operator_key),
        .equal_key      (equal_key),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output)
    );

    always #2 clk = ~clk;

    // Pulse counters, sampled away from the driving edge
    always @(negedge clk) begin
        if (key_read) begin
            ack_total = ack_total + 1;
        end
        if (complete) begin
            done_total = done_total + 1;
        end
    end

    task automatic check_display(input string name, input sm_word_t expected,
                                 input sm_word_t got);
        if (got.raw !== expected.raw) begin
            $display("ERROR at %0t ns: %s display sign %0b mag %0d, expected sign %0b mag %0d",
                     $time, name, got.f.sign, got.f.mag, expected.f.sign, expected.f.mag);
            errors = errors + 1;
        end
    endtask

    task automatic check_ack_count(input string name, input string what,
                                   input int expected, input int seen);
        if (seen != expected) begin
            $display("ERROR at %0t ns: %s saw %0d %s pulses, expected %0d",
                     $time, name, seen, what, expected);
            errors = errors + 1;
        end
    endtask

    task automatic report_timeout(input string name, input string what, input int limit);
        calc_state_t st;
        st = dut0.ctrl0.state;
        $display("Test %s gave up: %s did not arrive within %0d cycles, controller in %s",
                 name, what, limit, st.name());
        errors = errors + 1;
        timed_out = 1'b1;
    endtask

    function automatic logic [$bits(op_code_t)-1:0] op_code_for(input byte c);
        case (c)
            "n":     op_code_for = OP_NEG;
            "+":     op_code_for = OP_ADD;
            "-":     op_code_for = OP_SUB;
            "*":     op_code_for = OP_MUL;
            "p":     op_code_for = 3'd5;
            "q":     op_code_for = 3'd6;
            "r":     op_code_for = 3'd7;
            default: op_code_for = OP_NONE;
        endcase
    endfunction

    task automatic press_key(input string name, input byte c, input bit accepted);
        int idle;
        int n;
        bit seen;
        idle = $urandom % 4;
        seen = 1'b0;
        repeat (idle) @(posedge clk);
        @(posedge clk);
        if (c >= "0" && c <= "9") begin
            keypad_digit <= `CALC_DIGIT_W'(c - 8'd48);
            digit_valid  <= 1'b1;
        end else if (c == "=") begin
            equal_key <= 1'b1;
        end else begin
            operator_key <= op_code_for(c);
        end
        if (accepted) begin
            for (n = 0; n < KEY_TIMEOUT && !seen; n++) begin
                @(posedge clk);
                seen = key_read;
            end
            if (!seen) begin
                report_timeout(name, "key_read", KEY_TIMEOUT);
            end
        end else begin
            // Held long enough to reach a wait state
            for (n = 0; n < IGNORE_HOLD; n++) begin
                @(posedge clk);
                if (key_read || complete) begin
                    $display("ERROR at %0t ns: %s ignored key %c was acknowledged",
                             $time, name, c);
                    errors = errors + 1;
                end
            end
        end
        digit_valid  <= 1'b0;
        keypad_digit <= '0;
        operator_key <= OP_NONE;
        equal_key    <= 1'b0;
    endtask

    task automatic wait_complete(input string name);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < DONE_TIMEOUT && !seen; n++) begin
            @(posedge clk);
            seen = complete;
        end
        if (!seen) begin
            report_timeout(name, "complete", DONE_TIMEOUT);
        end
    endtask

    task automatic run_test(input string name, input string keys, input sm_word_t expected);
        int       i;
        int       acks_expected;
        int       done_expected;
        int       ack_start;
        int       done_start;
        int       errors_start;
        bit       op_seen;
        bit       accepted;
        byte      c;
        sm_word_t got;
        errors_start  = errors;
        ack_start     = ack_total;
        done_start    = done_total;
        acks_expected = 0;
        done_expected = 0;
        op_seen       = 1'b0;
        for (i = 0; i < keys.len() && !timed_out; i++) begin
            c = keys[i];
            // Acceptance follows the keypad rules, equals needs an operator first
            if ((c >= "0" && c <= "9") || c == "n") begin
                accepted = 1'b1;
            end else if (c == "+" || c == "-" || c == "*") begin
                accepted = !op_seen;
                op_seen  = 1'b1;
            end else if (c == "=") begin
                accepted = op_seen;
            end else begin
                accepted = 1'b0;
            end
            if (accepted) begin
                acks_expected = acks_expected + 1;
            end
            press_key(name, c, accepted);
            if (accepted && c == "=" && !timed_out) begin
                done_expected = done_expected + 1;
                wait_complete(name);
            end
        end
        if (!timed_out) begin
            repeat (4) @(posedge clk);
            got.raw = display_output;
            check_display(name, expected, got);
            check_ack_count(name, "key_read", acks_expected, ack_total - ack_start);
            check_ack_count(name, "complete", done_expected, done_total - done_start);
        end
        tests_run = tests_run + 1;
        if (errors != errors_start) begin
            tests_failed = tests_failed + 1;
        end
        $display("%s %-14s keys %-12s display %h", (errors == errors_start) ? "PASS" : "FAIL",
                 name, keys, display_output);
    endtask

    initial begin
        int                      fd;
        string                   line;
        string                   name;
        string                   keys;
        logic [`CALC_WORD_W-1:0] exp_raw;
        sm_word_t                expected;
        sm_word_t                got;
        void'($urandom(54780));
        clk          = 1'b0;
        nRST         = 1'b0;
        keypad_digit = '0;
        digit_valid  = 1'b0;
        operator_key = OP_NONE;
        equal_key    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        ack_total    = 0;
        done_total   = 0;
        timed_out    = 1'b0;
        repeat (16) @(posedge clk);
        nRST <= 1'b1;

        // Quiet outputs out of reset
        repeat (8) @(posedge clk);
        expected.raw = '0;
        got.raw      = display_output;
        check_display("reset", expected, got);
        check_ack_count("reset", "key_read", 0, ack_total);
        check_ack_count("reset", "complete", 0, done_total);
        $display("%s %-14s display %h", (errors == 0) ? "PASS" : "FAIL", "reset", display_output);

        fd = $fopen("bench/calc_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file bench/calc_vectors.txt");
            errors = errors + 1;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%s %s %h", name, keys, exp_raw) == 3) begin
                        expected.raw = exp_raw;
                        run_test(name, keys, expected);
                    end
                end
            end
            $fclose(fd);
            if (tests_run == 0) begin
                $display("No calculations were read from the vector file");
                errors = errors + 1;
            end
        end

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/calc_vectors.txt
# name  keys  expected display word in hex (bit 15 sign, bits 14..0 magnitude)
# keys: digits, n negate, + - * operators, = equals, p q r unused operator codes 5 to 7
add_multi 123+456= 0243
sub_cross 25-40= 800F
neg_cancel n7+7= 0000
mul_mixed n12*34= 8198
mul_zero 0*n5= 0000
wrap_entry 40000+0= 1C40
wrap_product 300*200= 6A60
ignore_keys =p12q+r3= 000F
ignore_equal =7=*8= 0038
sub_neg_both n5-n8= 0003
mul_neg_neg n3*n4= 000C
add_wrap 32767+1= 0000
neg_late 6*5n= 801E

//--- calc.f
+incdir+design
design/calc_pkg.sv
design/arith_if.sv
design/sm_adder.sv
design/sm_multiplier.sv
design/calc_controller.sv
design/calc_top.sv
bench/calc_tb.sv

//--- design/arith_if.sv
// Operand, strobe and result bundle between the controller and one arithmetic unit
`default_nettype none
`timescale 1ns/1ps

interface arith_if;
    import calc_pkg::*;

    // Driven by the controller
    sm_word_t a;
    sm_word_t b;
    logic     start;
    logic     sub;

    // Driven by the unit, result valid while finish is high
    sm_word_t result;
    logic     finish;

    modport master (
        output a, b, start, sub,
        input  result, finish
    );

    modport unit (
        input  a, b, start, sub,
        output result, finish
    );

endinterface

`default_nettype wire

//--- design/calc_controller.sv
// Keypad FSM building operands, launching add/sub/multiply and latching the display
`default_nettype none
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_controller (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic [`CALC_DIGIT_W-1:0] keypad_digit,
    input  logic                    digit_valid,
    input  calc_pkg::op_code_t      operator_key,
    input  logic                    equal_key,
    output logic                    key_read,
    output logic                    complete,
    output calc_pkg::sm_word_t      display_output,
    arith_if.master                 add_bus,
    arith_if.master                 mul_bus
);
    import calc_pkg::*;

    localparam sm_word_t RADIX_WORD = `CALC_WORD_W'(`CALC_RADIX);

    calc_state_t              state;
    calc_state_t              state_next;
    sm_word_t                 op1;
    sm_word_t                 op2;
    op_code_t                 op_r;
    logic [`CALC_DIGIT_W-1:0] digit_r;
    logic                     key_free;
    logic                     take_digit;
    logic                     take_neg;
    logic                     take_op;
    logic                     take_equal;
    logic                     in_shift;

    // A key still held while key_read is high was already consumed
    always_comb begin
        key_free   = !key_read;
        take_digit = key_free && digit_valid;
        take_neg   = key_free && !digit_valid && (operator_key == OP_NEG);
        take_op    = key_free && !digit_valid && (operator_key inside {OP_ADD, OP_SUB, OP_MUL});
        take_equal = key_free && !digit_valid && equal_key;
    end

    assign in_shift = (state == SHIFT_OP1) || (state == SHIFT_OP2);

    // Operand routing to the two units
    assign add_bus.a   = op1;
    assign add_bus.b   = op2;
    assign add_bus.sub = (op_r == OP_SUB);
    assign mul_bus.a   = (state == SHIFT_OP2) ? op2 : op1;
    assign mul_bus.b   = in_shift ? RADIX_WORD : op2;
    assign mul_bus.sub = 1'b0;

    always_comb begin
        state_next = state;
        case (state)
            WAIT_OP1: begin
                if (take_digit) begin
                    state_next = SHIFT_OP1;
                end else if (take_op) begin
                    state_next = WAIT_OP2;
                end
            end
            SHIFT_OP1:     state_next = mul_bus.finish ? ADD_DIGIT_OP1 : SHIFT_OP1;
            ADD_DIGIT_OP1: state_next = WAIT_OP1;
            WAIT_OP2: begin
                if (take_digit) begin
                    state_next = SHIFT_OP2;
                end else if (take_equal) begin
                    state_next = LAUNCH;
                end
            end
            SHIFT_OP2:     state_next = mul_bus.finish ? ADD_DIGIT_OP2 : SHIFT_OP2;
            ADD_DIGIT_OP2: state_next = WAIT_OP2;
            LAUNCH:        state_next = WAIT_COMPUTE;
            WAIT_COMPUTE: begin
                if (add_bus.finish || mul_bus.finish) begin
                    state_next = SHOW_RESULT;
                end
            end
            SHOW_RESULT:   state_next = WAIT_OP1;
            default:       state_next = WAIT_OP1;
        endcase
    end

    // Digit held for the add after the shift
    always_ff @(posedge clk) begin
        if ((state == WAIT_OP1 || state == WAIT_OP2) && take_digit) begin
            digit_r <= keypad_digit;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state              <= WAIT_OP1;
            op1                <= '0;
            op2                <= '0;
            op_r               <= OP_NONE;
            key_read           <= 1'b0;
            complete           <= 1'b0;
            display_output.raw <= '0;
            add_bus.start      <= 1'b0;
            mul_bus.start      <= 1'b0;
        end else begin
            state         <= state_next;
            key_read      <= 1'b0;
            complete      <= 1'b0;
            add_bus.start <= 1'b0;
            mul_bus.start <= 1'b0;
            case (state)
                WAIT_OP1: begin
                    if (take_digit) begin
                        key_read      <= 1'b1;
                        mul_bus.start <= 1'b1;
                    end else if (take_neg) begin
                        key_read    <= 1'b1;
                        op1.f.sign  <= !op1.f.sign;
                    end else if (take_op) begin
                        key_read <= 1'b1;
                        op_r     <= operator_key;
                    end
                end
                SHIFT_OP1: begin
                    // Sign stays with the operand, only the magnitude is shifted
                    if (mul_bus.finish) begin
                        op1.f.mag <= mul_bus.result.f.mag;
                    end
                end
                ADD_DIGIT_OP1: op1.f.mag <= op1.f.mag + `CALC_MAG_W'(digit_r);
                WAIT_OP2: begin
                    // Equals is acknowledged from LAUNCH
                    if (take_digit) begin
                        key_read      <= 1'b1;
                        mul_bus.start <= 1'b1;
                    end else if (take_neg) begin
                        key_read   <= 1'b1;
                        op2.f.sign <= !op2.f.sign;
                    end
                end
                SHIFT_OP2: begin
                    if (mul_bus.finish) begin
                        op2.f.mag <= mul_bus.result.f.mag;
                    end
                end
                ADD_DIGIT_OP2: op2.f.mag <= op2.f.mag + `CALC_MAG_W'(digit_r);
                LAUNCH: begin
                    key_read <= 1'b1;
                    if (op_r == OP_MUL) begin
                        mul_bus.start <= 1'b1;
                    end else begin
                        add_bus.start <= 1'b1;
                    end
                end
                WAIT_COMPUTE: begin
                    if (add_bus.finish) begin
                        display_output.raw <= add_bus.result.raw;
                        complete           <= 1'b1;
                    end else if (mul_bus.finish) begin
                        display_output.raw <= mul_bus.result.raw;
                        complete           <= 1'b1;
                    end
                end
                SHOW_RESULT: begin
                    // Fresh entry after every result
                    op1  <= '0;
                    op2  <= '0;
                    op_r <= OP_NONE;
                end
                default: begin
                    op_r <= OP_NONE;
                end
            endcase
        end
    end

    // Only one unit is ever launched at a time
    a_single_start: assert property (
        @(posedge clk) disable iff (!nRST) !(add_bus.start && mul_bus.start)
    ) else $error("adder and multiplier started together");

endmodule

`default_nettype wire

//--- design/calc_defines.svh
// Word, magnitude and digit widths plus the decimal radix for the calculator core
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// Full sign-magnitude word, sign in the top bit
`define CALC_WORD_W 16

// Magnitude field below the sign
`define CALC_MAG_W 15

// One keypad digit
`define CALC_DIGIT_W 4

// Decimal shift factor for digit entry
`define CALC_RADIX 10

`endif

//--- design/calc_pkg.sv
// Controller state type, operator codes and the sign-magnitude word union
`default_nettype none
`include "calc_defines.svh"

package calc_pkg;

    typedef enum logic [3:0] {
        WAIT_OP1      = 4'd0,
        SHIFT_OP1     = 4'd1,
        ADD_DIGIT_OP1 = 4'd2,
        WAIT_OP2      = 4'd3,
        SHIFT_OP2     = 4'd4,
        ADD_DIGIT_OP2 = 4'd5,
        LAUNCH        = 4'd6,
        WAIT_COMPUTE  = 4'd7,
        SHOW_RESULT   = 4'd8
    } calc_state_t;

    // Keypad operator codes, 5 to 7 unused
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_code_t;

    typedef struct packed {
        logic                   sign;
        logic [`CALC_MAG_W-1:0] mag;
    } sm_fields_t;

    // Same word seen raw or split into sign and magnitude
    typedef union packed {
        logic [`CALC_WORD_W-1:0] raw;
        sm_fields_t              f;
    } sm_word_t;

endpackage

`default_nettype wire

//--- design/calc_top.sv
// Calculator top level with the controller, adder, multiplier and their two buses
`default_nettype none
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_top (
    input  logic                                   clk,
    input  logic                                   nRST,
    input  logic [`CALC_DIGIT_W-1:0]               keypad_digit,
    input  logic                                   digit_valid,
    input  logic [$bits(calc_pkg::op_code_t)-1:0]  operator_key,
    input  logic                                   equal_key,
    output logic                                   key_read,
    output logic                                   complete,
    output logic [`CALC_WORD_W-1:0]                display_output
);

    arith_if add_bus ();
    arith_if mul_bus ();

    calc_controller ctrl0 (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_digit   (keypad_digit),
        .digit_valid    (digit_valid),
        .operator_key   (calc_pkg::op_code_t'(operator_key)),
        .equal_key      (equal_key),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output),
        .add_bus        (add_bus),
        .mul_bus        (mul_bus)
    );

    sm_adder add0 (
        .clk  (clk),
        .nRST (nRST),
        .bus  (add_bus)
    );

    sm_multiplier mul0 (
        .clk  (clk),
        .nRST (nRST),
        .bus  (mul_bus)
    );

endmodule

`default_nettype wire

//--- design/sm_adder.sv
// Two-stage sign-magnitude adder and subtractor on the arithmetic bus
`default_nettype none
`timescale 1ns/1ps
`include "calc_defines.svh"

module sm_adder (
    input  logic   clk,
    input  logic   nRST,
    arith_if.unit  bus
);
    import calc_pkg::*;

    logic                   valid_s1;
    logic                   same_sign_s1;
    logic                   big_sign_s1;
    logic [`CALC_MAG_W-1:0] big_mag_s1;
    logic [`CALC_MAG_W-1:0] small_mag_s1;
    logic                   b_sign_eff;
    logic                   a_is_big;
    logic [`CALC_MAG_W-1:0] mag_out;
    sm_word_t               sum_word;

    // Subtract is an add with b's sign flipped
    assign b_sign_eff = bus.b.f.sign ^ bus.sub;
    assign a_is_big   = bus.a.f.mag >= bus.b.f.mag;

    // Stage one orders the operands by magnitude
    always_ff @(posedge clk) begin
        if (bus.start) begin
            same_sign_s1 <= (bus.a.f.sign == b_sign_eff);
            if (a_is_big) begin
                big_mag_s1   <= bus.a.f.mag;
                small_mag_s1 <= bus.b.f.mag;
                big_sign_s1  <= bus.a.f.sign;
            end else begin
                big_mag_s1   <= bus.b.f.mag;
                small_mag_s1 <= bus.a.f.mag;
                big_sign_s1  <= b_sign_eff;
            end
        end
    end

    // Stage two, wraps modulo 2^15
    always_comb begin
        mag_out = same_sign_s1 ? big_mag_s1 + small_mag_s1 : big_mag_s1 - small_mag_s1;
        sum_word.f.mag  = mag_out;
        sum_word.f.sign = big_sign_s1 && (mag_out != '0);
    end

    always_ff @(posedge clk) begin
        if (valid_s1) begin
            bus.result <= sum_word;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            valid_s1   <= 1'b0;
            bus.finish <= 1'b0;
        end else begin
            valid_s1   <= bus.start;
            bus.finish <= valid_s1;
        end
    end

    // Fixed latency seen by the controller
    a_finish_after_two: assert property (
        @(posedge clk) disable iff (!nRST) bus.start |-> ##2 bus.finish
    ) else $error("adder finish not two cycles after start");

endmodule

`default_nettype wire

//--- design/sm_multiplier.sv
// Iterative shift-and-add sign-magnitude multiplier on the arithmetic bus
`default_nettype none
`timescale 1ns/1ps
`include "calc_defines.svh"

module sm_multiplier (
    input  logic   clk,
    input  logic   nRST,
    arith_if.unit  bus
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(`CALC_MAG_W);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`CALC_MAG_W - 1);

    logic                   busy;
    logic [CNT_W-1:0]       step;
    logic                   last_step;
    logic [`CALC_MAG_W-1:0] acc;
    logic [`CALC_MAG_W-1:0] acc_next;
    logic [`CALC_MAG_W-1:0] mcand;
    logic [`CALC_MAG_W-1:0] mplier;
    logic                   sign_r;
    sm_word_t               product;

    assign last_step = busy && (step == LAST_STEP);

    // One multiplier bit per cycle, high bits of the partial sums drop off
    assign acc_next = mplier[0] ? acc + mcand : acc;

    always_comb begin
        product.f.mag  = acc_next;
        product.f.sign = sign_r && (acc_next != '0);
    end

    // Control, counts 15 steps after capture
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy       <= 1'b0;
            step       <= '0;
            bus.finish <= 1'b0;
        end else begin
            bus.finish <= 1'b0;
            if (bus.start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy       <= 1'b0;
                    bus.finish <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (bus.start) begin
            acc    <= '0;
            mcand  <= bus.a.f.mag;
            mplier <= bus.b.f.mag;
            sign_r <= bus.a.f.sign ^ bus.b.f.sign;
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (last_step) begin
                bus.result <= product;
            end
        end
    end

    // Controller must wait for finish
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!nRST) busy |-> !bus.start
    ) else $error("multiplier started while busy");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module calc_tb -f calc.f \
    --Mdir obj_dir -o calc_sim

./obj_dir/calc_sim > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
